// File: common/axi_mem_consts.svh
// Width and depth constants for the AXI4 to memory bridge.
// Include this header wherever a width or the buffer depth is needed.
`ifndef AXI_MEM_CONSTS_SVH
`define AXI_MEM_CONSTS_SVH

// Byte address width of the memory port.
`define AXI_MEM_ADDR_W 16
// AXI and memory data width.
`define AXI_MEM_DATA_W 32
// AXI ID width.
`define AXI_MEM_ID_W 4
// AXI burst length field width.
`define AXI_MEM_LEN_W 8
// AXI QoS field width.
`define AXI_MEM_QOS_W 4
// Response buffer depth.
// Also the limit on memory requests in flight.
`define AXI_MEM_BUF_DEPTH 4

`endif

// File: common/axi_mem_pkg.sv
// Shared types of the AXI4 to memory bridge.
// AXI channel payloads, internal beats, memory request and response.
`include "axi_mem_consts.svh"

package axi_mem_pkg;

  typedef logic [`AXI_MEM_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_MEM_DATA_W-1:0]   data_t;
  typedef logic [`AXI_MEM_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_MEM_ID_W-1:0]     id_t;
  typedef logic [`AXI_MEM_LEN_W-1:0]    len_t;
  typedef logic [`AXI_MEM_QOS_W-1:0]    qos_t;

  // AXI response codes that the bridge can return.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_e;

  // AW and AR payload; only INCR bursts are handled.
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    logic [2:0] size;
    qos_t       qos;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  // One memory access as produced by a burst sequencer.
  // Single marks a burst of one beat.
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    strb_t strb;
    id_t   id;
    qos_t  qos;
    logic  last;
    logic  single;
  } beat_t;

  // Context kept per request until its response returns.
  typedef struct packed {
    id_t  id;
    logic we;
    logic last;
  } ctx_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    strb_t strb;
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } mem_rsp_t;

endpackage

// File: src/burst/rd_burst_seq.sv
// Read burst sequencer.
// Expands one AR into len+1 read beats, first beat straight from AR.
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module rd_burst_seq (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  axi_mem_pkg::ax_chan_t ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output axi_mem_pkg::beat_t    beat_o,
  output logic                  beat_valid_o,
  input  logic                  beat_ready_i,
  output logic                  busy_o
);

  // Beats still to come after the current one.
  logic [`AXI_MEM_LEN_W-1:0] cnt_q;
  axi_mem_pkg::addr_t        addr_q;
  axi_mem_pkg::addr_t        incr_q;
  axi_mem_pkg::addr_t        incr;
  axi_mem_pkg::id_t          id_q;
  axi_mem_pkg::qos_t         qos_q;
  logic                      take;

  // Address step of 2^size bytes.
  assign incr         = axi_mem_pkg::addr_t'(1) << ar_i.size;
  assign busy_o       = (cnt_q != '0);
  assign beat_valid_o = busy_o | ar_valid_i;
  assign take         = beat_valid_o & beat_ready_i;
  // AR is consumed together with its first beat.
  assign ar_ready_o   = take & ~busy_o;

  always_comb begin
    beat_o = '0;
    if (busy_o) begin
      beat_o.addr = addr_q;
      beat_o.id   = id_q;
      beat_o.qos  = qos_q;
      beat_o.last = (cnt_q == `AXI_MEM_LEN_W'(1));
    end else begin
      // First beat keeps the unaligned address.
      beat_o.addr   = ar_i.addr;
      beat_o.id     = ar_i.id;
      beat_o.qos    = ar_i.qos;
      beat_o.last   = (ar_i.len == '0);
      beat_o.single = (ar_i.len == '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (take) begin
      cnt_q <= busy_o ? cnt_q - `AXI_MEM_LEN_W'(1) : ar_i.len;
    end
  end

  // Burst state, loaded when the AR is taken.
  always_ff @(posedge clk_i) begin
    if (take) begin
      if (busy_o) begin
        addr_q <= addr_q + incr_q;
      end else begin
        // Second beat is the aligned address plus one step.
        addr_q <= (ar_i.addr & ~(incr - axi_mem_pkg::addr_t'(1))) + incr;
        incr_q <= incr;
        id_q   <= ar_i.id;
        qos_q  <= ar_i.qos;
      end
    end
  end

endmodule

// File: src/burst/wr_burst_seq.sv
// Write burst sequencer.
// Expands one AW and its W beats into write beats; a burst starts on AW with W.
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module wr_burst_seq (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  axi_mem_pkg::ax_chan_t aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  axi_mem_pkg::w_chan_t  w_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  output axi_mem_pkg::beat_t    beat_o,
  output logic                  beat_valid_o,
  input  logic                  beat_ready_i,
  output logic                  busy_o
);

  // W beats still expected after the current one.
  logic [`AXI_MEM_LEN_W-1:0] cnt_q;
  axi_mem_pkg::addr_t        addr_q;
  axi_mem_pkg::addr_t        incr_q;
  axi_mem_pkg::addr_t        incr;
  axi_mem_pkg::id_t          id_q;
  axi_mem_pkg::qos_t         qos_q;
  logic                      take;

  assign incr   = axi_mem_pkg::addr_t'(1) << aw_i.size;
  assign busy_o = (cnt_q != '0);
  // No beat without write data.
  // A new burst also needs AW.
  assign beat_valid_o = w_valid_i & (busy_o | aw_valid_i);
  assign take         = beat_valid_o & beat_ready_i;
  assign w_ready_o    = take;
  assign aw_ready_o   = take & ~busy_o;

  always_comb begin
    beat_o       = '0;
    beat_o.we    = 1'b1;
    beat_o.wdata = w_i.data;
    beat_o.strb  = w_i.strb;
    if (busy_o) begin
      beat_o.addr = addr_q;
      beat_o.id   = id_q;
      beat_o.qos  = qos_q;
      beat_o.last = (cnt_q == `AXI_MEM_LEN_W'(1));
    end else begin
      beat_o.addr   = aw_i.addr;
      beat_o.id     = aw_i.id;
      beat_o.qos    = aw_i.qos;
      beat_o.last   = (aw_i.len == '0);
      beat_o.single = (aw_i.len == '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (take) begin
      cnt_q <= busy_o ? cnt_q - `AXI_MEM_LEN_W'(1) : aw_i.len;
    end
  end

  // Burst state.
  always_ff @(posedge clk_i) begin
    if (take) begin
      if (busy_o) begin
        addr_q <= addr_q + incr_q;
      end else begin
        addr_q <= (aw_i.addr & ~(incr - axi_mem_pkg::addr_t'(1))) + incr;
        incr_q <= incr;
        id_q   <= aw_i.id;
        qos_q  <= aw_i.qos;
      end
    end
  end

endmodule

// File: src/rw_arbiter.sv
// Read/write beat arbiter.
// Picks one beat stream and forks it atomically to the memory port and context FIFO.
`timescale 1ns/1ps

module rw_arbiter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  axi_mem_pkg::beat_t rd_beat_i,
  input  logic               rd_valid_i,
  input  logic               rd_busy_i,
  output logic               rd_ready_o,
  input  axi_mem_pkg::beat_t wr_beat_i,
  input  logic               wr_valid_i,
  input  logic               wr_busy_i,
  output logic               wr_ready_o,
  output axi_mem_pkg::beat_t beat_o,
  output logic               mem_valid_o,
  input  logic               mem_ready_i,
  output logic               ctx_valid_o,
  input  logic               ctx_ready_i
);

  // Selection, high picks the write stream.
  logic sel;
  logic sel_q;
  logic lock_q;
  logic valid;
  logic ready;

  always_comb begin
    sel = sel_q;
    if (lock_q) begin
      // Refused offer stays on the same stream.
      sel = sel_q;
    end else if (wr_valid_i ^ rd_valid_i) begin
      sel = wr_valid_i;
    end else if (wr_valid_i && rd_valid_i) begin
      if (wr_beat_i.qos != rd_beat_i.qos) begin
        sel = (wr_beat_i.qos > rd_beat_i.qos);
      end else if (wr_beat_i.single && !rd_beat_i.single) begin
        // Single write ahead of a read burst.
        sel = 1'b1;
      end else if (wr_busy_i) begin
        sel = 1'b1;
      end else if (rd_busy_i) begin
        sel = 1'b0;
      end else begin
        // Alternate to avoid starvation.
        sel = ~sel_q;
      end
    end
  end

  assign beat_o = sel ? wr_beat_i : rd_beat_i;
  assign valid  = sel ? wr_valid_i : rd_valid_i;
  // Both consumers must take the beat in the same cycle.
  assign ready       = mem_ready_i & ctx_ready_i;
  assign mem_valid_o = valid & ctx_ready_i;
  assign ctx_valid_o = valid & mem_ready_i;
  assign rd_ready_o  = ~sel & ready;
  assign wr_ready_o  = sel & ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      sel_q  <= sel;
      lock_q <= valid & ~ready;
    end
  end

endmodule

// File: src/resp/beat_fifo.sv
// Fall-through FIFO for beat context and memory responses.
// Data pushed into an empty FIFO appears at the output in the same cycle.
`timescale 1ns/1ps

module beat_fifo #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [Width-1:0]           data_i,
  input  logic                       valid_i,
  output logic                       ready_o,
  output logic [Width-1:0]           data_o,
  output logic                       valid_o,
  input  logic                       ready_i,
  output logic [$clog2(Depth+1)-1:0] count_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic             empty;
  logic             push;
  logic             pop;
  logic             store;
  logic             drop;

  assign empty   = (count_o == '0);
  assign ready_o = (count_o < Depth);
  assign valid_o = ~empty | valid_i;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;
  // Bypassed entries never touch the storage.
  assign store = push & ~(empty & pop);
  assign drop  = pop & ~empty;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end else begin
      if (store) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (drop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_o <= count_o + store - drop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (store) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: src/mem_port.sv
// Memory request port.
// Issues beats as req/gnt requests while the response buffer still has room.
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module mem_port (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  axi_mem_pkg::beat_t                        beat_i,
  input  logic                                      beat_valid_i,
  output logic                                      beat_ready_o,
  output logic                                      mem_req_o,
  output axi_mem_pkg::mem_req_t                     mem_req_data_o,
  input  logic                                      mem_gnt_i,
  input  logic                                      rsp_pop_i,
  input  logic [$clog2(`AXI_MEM_BUF_DEPTH+1)-1:0] rsp_count_i
);

  localparam int unsigned CntW = $clog2(`AXI_MEM_BUF_DEPTH + 1);

  // Granted requests whose response has not arrived yet.
  logic [CntW-1:0] out_q;
  logic            room;
  logic            granted;

  // Slots are counted against the responses already buffered.
  // Each granted request keeps one response slot.
  assign room = ({1'b0, out_q} + {1'b0, rsp_count_i}) < (CntW + 1)'(`AXI_MEM_BUF_DEPTH);

  assign mem_req_o    = beat_valid_i & room;
  assign beat_ready_o = room & mem_gnt_i;
  assign granted      = mem_req_o & mem_gnt_i;

  assign mem_req_data_o.addr  = beat_i.addr;
  assign mem_req_data_o.we    = beat_i.we;
  assign mem_req_data_o.wdata = beat_i.wdata;
  assign mem_req_data_o.strb  = beat_i.strb;

  // The response leaves the memory on rsp_pop_i.
  // It then sits in the response FIFO.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
    end else begin
      out_q <= out_q + granted - rsp_pop_i;
    end
  end

endmodule

// File: src/resp/resp_router.sv
// Response router.
// Joins each memory response with its beat context and drives R or B.
`timescale 1ns/1ps

module resp_router (
  input  axi_mem_pkg::ctx_t     ctx_i,
  input  logic                  ctx_valid_i,
  output logic                  ctx_ready_o,
  input  axi_mem_pkg::mem_rsp_t rsp_i,
  input  logic                  rsp_valid_i,
  output logic                  rsp_ready_o,
  output axi_mem_pkg::r_chan_t  r_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output axi_mem_pkg::b_chan_t  b_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i
);

  logic               both;
  logic               to_r;
  logic               to_b;
  logic               sink_ready;
  axi_mem_pkg::resp_e resp;

  assign both = ctx_valid_i & rsp_valid_i;
  assign to_r = ~ctx_i.we;
  assign to_b = ctx_i.we & ctx_i.last;
  assign resp = rsp_i.err ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;

  // Non-last write beats are dropped without a channel.
  assign sink_ready = to_r ? r_ready_i : (to_b ? b_ready_i : 1'b1);

  assign r_valid_o = both & to_r;
  assign b_valid_o = both & to_b;

  // Both FIFOs are popped together.
  assign ctx_ready_o = rsp_valid_i & sink_ready;
  assign rsp_ready_o = ctx_valid_i & sink_ready;

  assign r_o.id   = ctx_i.id;
  assign r_o.data = rsp_i.rdata;
  assign r_o.resp = resp;
  assign r_o.last = ctx_i.last;

  assign b_o.id   = ctx_i.id;
  assign b_o.resp = resp;

endmodule

// File: src/axi_to_mem.sv
// AXI4 slave to single-port memory bridge, top level.
// Sequencers, arbiter, memory port and response router in one pipeline.
`timescale 1ns/1ps
`include "axi_mem_consts.svh"

module axi_to_mem (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  axi_mem_pkg::ax_chan_t aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  axi_mem_pkg::w_chan_t  w_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  axi_mem_pkg::ax_chan_t ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output axi_mem_pkg::r_chan_t  r_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output axi_mem_pkg::b_chan_t  b_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output logic                  mem_req_o,
  output axi_mem_pkg::mem_req_t mem_req_data_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  axi_mem_pkg::mem_rsp_t mem_rsp_i,
  output logic                  busy_o
);

  localparam int unsigned CntW = $clog2(`AXI_MEM_BUF_DEPTH + 1);

  axi_mem_pkg::beat_t    rd_beat, wr_beat, arb_beat;
  logic                  rd_valid, rd_ready, rd_busy;
  logic                  wr_valid, wr_ready, wr_busy;
  logic                  mem_valid, mem_ready;
  logic                  ctx_push_valid, ctx_push_ready;
  axi_mem_pkg::ctx_t     ctx_in, ctx_out;
  logic                  ctx_valid, ctx_ready;
  axi_mem_pkg::mem_rsp_t rsp_out;
  logic                  rsp_valid, rsp_ready;
  logic [CntW-1:0]       rsp_count;

  rd_burst_seq rd_seq_i (
    .clk_i, .rst_n_i, .ar_i, .ar_valid_i, .ar_ready_o,
    .beat_o(rd_beat), .beat_valid_o(rd_valid), .beat_ready_i(rd_ready), .busy_o(rd_busy)
  );

  wr_burst_seq wr_seq_i (
    .clk_i, .rst_n_i, .aw_i, .aw_valid_i, .aw_ready_o, .w_i, .w_valid_i, .w_ready_o,
    .beat_o(wr_beat), .beat_valid_o(wr_valid), .beat_ready_i(wr_ready), .busy_o(wr_busy)
  );

  rw_arbiter arb_i (
    .clk_i, .rst_n_i,
    .rd_beat_i(rd_beat), .rd_valid_i(rd_valid), .rd_busy_i(rd_busy), .rd_ready_o(rd_ready),
    .wr_beat_i(wr_beat), .wr_valid_i(wr_valid), .wr_busy_i(wr_busy), .wr_ready_o(wr_ready),
    .beat_o(arb_beat), .mem_valid_o(mem_valid), .mem_ready_i(mem_ready),
    .ctx_valid_o(ctx_push_valid), .ctx_ready_i(ctx_push_ready)
  );

  mem_port port_i (
    .clk_i, .rst_n_i, .beat_i(arb_beat), .beat_valid_i(mem_valid), .beat_ready_o(mem_ready),
    .mem_req_o, .mem_req_data_o, .mem_gnt_i, .rsp_pop_i(mem_rvalid_i), .rsp_count_i(rsp_count)
  );

  // Context of each granted beat, consumed with its response.
  assign ctx_in = '{id: arb_beat.id, we: arb_beat.we, last: arb_beat.last};

  beat_fifo #(.Width($bits(axi_mem_pkg::ctx_t)), .Depth(`AXI_MEM_BUF_DEPTH)) ctx_fifo_i (
    .clk_i, .rst_n_i, .data_i(ctx_in), .valid_i(ctx_push_valid), .ready_o(ctx_push_ready),
    .data_o(ctx_out), .valid_o(ctx_valid), .ready_i(ctx_ready), .count_o()
  );

  // The memory port keeps a free slot for every response.
  beat_fifo #(.Width($bits(axi_mem_pkg::mem_rsp_t)), .Depth(`AXI_MEM_BUF_DEPTH)) rsp_fifo_i (
    .clk_i, .rst_n_i, .data_i(mem_rsp_i), .valid_i(mem_rvalid_i), .ready_o(),
    .data_o(rsp_out), .valid_o(rsp_valid), .ready_i(rsp_ready), .count_o(rsp_count)
  );

  resp_router router_i (
    .ctx_i(ctx_out), .ctx_valid_i(ctx_valid), .ctx_ready_o(ctx_ready),
    .rsp_i(rsp_out), .rsp_valid_i(rsp_valid), .rsp_ready_o(rsp_ready),
    .r_o, .r_valid_o, .r_ready_i, .b_o, .b_valid_o, .b_ready_i
  );

  // Context FIFO is non-empty while any request is outstanding.
  assign busy_o = rd_busy | wr_busy | ctx_valid | rsp_valid |
                  aw_valid_i | w_valid_i | ar_valid_i | r_valid_o | b_valid_o;

endmodule

// File: dv/tb_mem_slave.sv
// Behavioral single-port memory for the bridge testbench.
// Random grant, in-order responses 1 to 4 cycles after grant, err for addresses 0xFxxx.
`timescale 1ns/1ps

module tb_mem_slave (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  axi_mem_pkg::mem_req_t req_data_i,
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output axi_mem_pkg::mem_rsp_t rsp_o
);

  logic [7:0]            mem_q [0:65535];
  // Pending responses and the cycle each one is due.
  axi_mem_pkg::mem_rsp_t rsp_q [$];
  int unsigned           due_q [$];
  int unsigned           cycle;
  int unsigned           last_due;

  // Start content, built from every address bit.
  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'hA5;
  endfunction

  initial begin
    for (int a = 0; a < 65536; a++) begin
      mem_q[a] = fill_byte(16'(a));
    end
    cycle    = 0;
    last_due = 0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rsp_o    = '0;
  end

  always @(posedge clk_i) begin : serve
    axi_mem_pkg::mem_rsp_t rsp;
    logic [15:0]           base;
    int unsigned           due;
    logic                  rst_seen;
    rst_seen = rst_n_i;
    cycle++;
    if (!rst_seen) begin
      rsp_q.delete();
      due_q.delete();
    end else if (req_i && gnt_o) begin
      base      = {req_data_i.addr[15:2], 2'b00};
      rsp.err   = (req_data_i.addr[15:12] == 4'hF);
      rsp.rdata = '0;
      // Error region is neither read nor written.
      if (!rsp.err) begin
        for (int k = 0; k < 4; k++) begin
          if (!req_data_i.we) begin
            rsp.rdata[8*k +: 8] = mem_q[base + k];
          end else if (req_data_i.strb[k]) begin
            mem_q[base + k] = req_data_i.wdata[8*k +: 8];
          end
        end
      end
      // Random latency, pushed back so responses stay in order.
      due = cycle + $urandom_range(3);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rsp_q.push_back(rsp);
      due_q.push_back(due);
    end
    #1;
    gnt_o    = rst_seen && ($urandom_range(99) < 70);
    rvalid_o = 1'b0;
    if (due_q.size() > 0 && due_q[0] <= cycle) begin
      void'(due_q.pop_front());
      rsp_o    = rsp_q.pop_front();
      rvalid_o = 1'b1;
    end
  end

endmodule

// File: dv/tb_axi_to_mem.sv
// Testbench for the AXI4 to memory bridge.
// Random AXI traffic checked against a byte-level reference model.
`timescale 1ns/1ps

module tb_axi_to_mem;

  // Transactions over all tests set the run limit.
  localparam int unsigned TXNS       = 62;
  localparam int unsigned MAX_CYCLES = TXNS * 256 * 8 + 1000;

  logic                  clk_i;
  logic                  rst_n_i;
  axi_mem_pkg::ax_chan_t aw;
  logic                  aw_valid;
  logic                  aw_ready;
  axi_mem_pkg::w_chan_t  w;
  logic                  w_valid;
  logic                  w_ready;
  axi_mem_pkg::ax_chan_t ar;
  logic                  ar_valid;
  logic                  ar_ready;
  axi_mem_pkg::r_chan_t  r;
  logic                  r_valid;
  logic                  r_ready;
  axi_mem_pkg::b_chan_t  b;
  logic                  b_valid;
  logic                  b_ready;
  logic                  mem_req;
  axi_mem_pkg::mem_req_t mem_req_data;
  logic                  mem_gnt;
  logic                  mem_rvalid;
  axi_mem_pkg::mem_rsp_t mem_rsp;
  logic                  busy;

  // Reference memory with one entry per byte address.
  logic [7:0]            model_mem [0:65535];
  axi_mem_pkg::r_chan_t  exp_r [$];
  axi_mem_pkg::b_chan_t  exp_b [$];
  axi_mem_pkg::ax_chan_t saved_ax [$];
  int unsigned           errors;
  int unsigned           checks;
  int unsigned           cycle_cnt;
  // Random response ready and gaps in the AXI traffic.
  logic                  bp_mode;

  axi_to_mem axi_to_mem_i (
    .clk_i, .rst_n_i,
    .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
    .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
    .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
    .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready),
    .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready),
    .mem_req_o(mem_req), .mem_req_data_o(mem_req_data), .mem_gnt_i(mem_gnt),
    .mem_rvalid_i(mem_rvalid), .mem_rsp_i(mem_rsp), .busy_o(busy)
  );

  tb_mem_slave mem_i (
    .clk_i, .rst_n_i, .req_i(mem_req), .req_data_i(mem_req_data),
    .gnt_o(mem_gnt), .rvalid_o(mem_rvalid), .rsp_o(mem_rsp)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // Same start content as the behavioral memory.
  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'hA5;
  endfunction

  // INCR address of beat i.
  // The first beat is unaligned and later beats step from the aligned address.
  function automatic logic [15:0] beat_addr(input axi_mem_pkg::ax_chan_t ax, input int i);
    logic [15:0] step;
    logic [15:0] aligned;
    step    = 16'd1 << ax.size;
    aligned = ax.addr & ~(step - 16'd1);
    if (i == 0) begin
      return ax.addr;
    end
    return aligned + 16'(step * i);
  endfunction

  function automatic logic [31:0] read_word(input logic [15:0] a);
    logic [15:0] base;
    base = a & 16'hFFFC;
    return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
  endfunction

  function automatic axi_mem_pkg::ax_chan_t random_ax(input logic [15:0] base,
                                                      input int unsigned span,
                                                      input int unsigned max_len);
    axi_mem_pkg::ax_chan_t ax;
    ax.id   = $urandom();
    ax.addr = base + 16'($urandom_range(span - 1));
    ax.len  = $urandom_range(max_len);
    ax.size = $urandom_range(2);
    ax.qos  = $urandom();
    return ax;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Queues the expected R beats, then hands over the AR.
  task automatic send_read(input axi_mem_pkg::ax_chan_t ax);
    axi_mem_pkg::r_chan_t e;
    logic                 err;
    err = (ax.addr[15:12] == 4'hF);
    for (int i = 0; i <= ax.len; i++) begin
      e.id   = ax.id;
      e.data = err ? '0 : read_word(beat_addr(ax, i));
      e.resp = err ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;
      e.last = (i == ax.len);
      exp_r.push_back(e);
    end
    if (bp_mode) begin
      idle_cycles($urandom_range(2));
    end
    ar       = ax;
    ar_valid = 1'b1;
    do @(posedge clk_i); while (ar_ready !== 1'b1);
    #1;
    ar_valid = 1'b0;
  endtask

  // AW goes out with the first W beat; the model takes each beat's strobe.
  task automatic send_write(input axi_mem_pkg::ax_chan_t ax);
    axi_mem_pkg::b_chan_t e;
    logic [15:0]          base;
    logic                 err;
    err    = (ax.addr[15:12] == 4'hF);
    e.id   = ax.id;
    e.resp = err ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;
    exp_b.push_back(e);
    for (int i = 0; i <= ax.len; i++) begin
      if (bp_mode) begin
        idle_cycles($urandom_range(2));
      end
      w.data = $urandom();
      w.strb = $urandom();
      w.last = (i == ax.len);
      base   = beat_addr(ax, i) & 16'hFFFC;
      for (int k = 0; k < 4; k++) begin
        if (!err && w.strb[k]) begin
          model_mem[base + k] = w.data[8*k +: 8];
        end
      end
      w_valid = 1'b1;
      if (i == 0) begin
        aw       = ax;
        aw_valid = 1'b1;
      end
      do @(posedge clk_i); while (w_ready !== 1'b1);
      // The burst address is taken together with its first data beat.
      if (i == 0) begin
        compare_value("aw_ready_o", aw_ready, 1'b1);
      end
      #1;
      w_valid  = 1'b0;
      aw_valid = 1'b0;
    end
  endtask

  task automatic check_first_request(input logic exp_we);
    do @(posedge clk_i); while (mem_req !== 1'b1);
    compare_value("mem_req_data_o.we", mem_req_data.we, exp_we);
  endtask

  // Waits until every expected response has arrived.
  task automatic drain();
    while (exp_r.size() != 0 || exp_b.size() != 0) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic report_test(input int num, input string name, input int unsigned err_base);
    $display("test %0d, %s: %0d errors", num, name, errors - err_base);
  endtask

  always @(posedge clk_i) begin : r_monitor
    axi_mem_pkg::r_chan_t e;
    if (rst_n_i && r_valid && r_ready) begin
      if (exp_r.size() == 0) begin
        errors++;
        $display("R beat with id %h arrived with no read outstanding.", r.id);
      end else begin
        e = exp_r.pop_front();
        compare_value("r_o.id", r.id, e.id);
        compare_value("r_o.data", r.data, e.data);
        compare_value("r_o.resp", r.resp, e.resp);
        compare_value("r_o.last", r.last, e.last);
      end
    end
  end

  always @(posedge clk_i) begin : b_monitor
    axi_mem_pkg::b_chan_t e;
    if (rst_n_i && b_valid && b_ready) begin
      if (exp_b.size() == 0) begin
        errors++;
        $display("B response with id %h arrived with no write outstanding.", b.id);
      end else begin
        e = exp_b.pop_front();
        compare_value("b_o.id", b.id, e.id);
        compare_value("b_o.resp", b.resp, e.resp);
      end
    end
  end

  // Response ready is random under back-pressure.
  always @(posedge clk_i) begin
    #1;
    r_ready = bp_mode ? ($urandom_range(1) == 1) : 1'b1;
    b_ready = bp_mode ? ($urandom_range(1) == 1) : 1'b1;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Run stopped after %0d cycles, traffic never drained.", cycle_cnt);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int unsigned           err_base;
    axi_mem_pkg::ax_chan_t ax;
    axi_mem_pkg::ax_chan_t ax_rd;
    void'($urandom(32'h4fe8b40f));
    rst_n_i  = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b1;
    b_ready  = 1'b1;
    bp_mode  = 1'b0;
    errors   = 0;
    checks   = 0;
    for (int a = 0; a < 65536; a++) begin
      model_mem[a] = fill_byte(16'(a));
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Idle outputs after reset.
    err_base = errors;
    repeat (3) @(posedge clk_i);
    compare_value("r_valid_o", r_valid, 1'b0);
    compare_value("b_valid_o", b_valid, 1'b0);
    compare_value("mem_req_o", mem_req, 1'b0);
    compare_value("busy_o", busy, 1'b0);
    #1;
    report_test(1, "reset", err_base);

    // Single-beat writes, then reads of the same addresses.
    err_base = errors;
    saved_ax.delete();
    for (int i = 0; i < 8; i++) begin
      ax      = random_ax(16'h0000, 16'hD000, 0);
      ax.size = 3'd2;
      saved_ax.push_back(ax);
      send_write(ax);
    end
    drain();
    foreach (saved_ax[i]) begin
      ax    = saved_ax[i];
      ax.id = $urandom();
      send_read(ax);
    end
    drain();
    report_test(2, "single writes then reads", err_base);

    // Long bursts whose reads cover the written ranges.
    err_base = errors;
    saved_ax.delete();
    for (int i = 0; i < 8; i++) begin
      ax = random_ax(16'h0000, 16'hCC00, 255);
      saved_ax.push_back(ax);
      send_write(ax);
    end
    drain();
    foreach (saved_ax[i]) begin
      ax    = saved_ax[i];
      ax.id = $urandom();
      send_read(ax);
    end
    drain();
    report_test(3, "random bursts", err_base);

    // Bursts into the 0xFxxx error region.
    err_base = errors;
    send_read(random_ax(16'hF000, 16'h0800, 15));
    send_write(random_ax(16'hF000, 16'h0800, 15));
    drain();
    report_test(4, "error region", err_base);

    // Higher QoS wins the first memory request.
    err_base = errors;
    for (int k = 0; k < 2; k++) begin
      ax         = random_ax(16'h2000, 16'h0100, 0);
      ax.qos     = (k == 0) ? 4'd15 : 4'd0;
      ax_rd      = random_ax(16'h3000, 16'h0100, 0);
      ax_rd.len  = 8'd3;
      ax_rd.qos  = (k == 0) ? 4'd0 : 4'd15;
      fork
        send_write(ax);
        send_read(ax_rd);
        check_first_request(k == 0);
      join
      drain();
    end
    report_test(5, "qos priority", err_base);

    // Concurrent reads and writes on disjoint ranges under back-pressure.
    err_base = errors;
    bp_mode  = 1'b1;
    fork
      for (int i = 0; i < 12; i++) send_write(random_ax(16'h8000, 16'h4000, 31));
      for (int i = 0; i < 12; i++) send_read(random_ax(16'h0000, 16'h3C00, 31));
    join
    drain();
    @(posedge clk_i);
    compare_value("busy_o", busy, 1'b0);
    #1;
    bp_mode = 1'b0;
    report_test(6, "back-pressure", err_base);

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+common
common/axi_mem_pkg.sv
src/burst/rd_burst_seq.sv
src/burst/wr_burst_seq.sv
src/rw_arbiter.sv
src/resp/beat_fifo.sv
src/mem_port.sv
src/resp/resp_router.sv
src/axi_to_mem.sv
dv/tb_mem_slave.sv
dv/tb_axi_to_mem.sv

// File: Bender.yml
package:
  name: axi_to_mem

export_include_dirs:
  - common

sources:
  - common/axi_mem_pkg.sv
  - src/burst/rd_burst_seq.sv
  - src/burst/wr_burst_seq.sv
  - src/rw_arbiter.sv
  - src/resp/beat_fifo.sv
  - src/mem_port.sv
  - src/resp/resp_router.sv
  - src/axi_to_mem.sv
  - target: test
    files:
      - dv/tb_mem_slave.sv
      - dv/tb_axi_to_mem.sv
